// ==== source/mem_pkg.sv ====
package mem_pkg;

    // Data path and byte lane geometry
    localparam int data_w      = 32;
    localparam int lanes       = 4;
    localparam int lane_sel_w  = 2;   // Low address bits that pick a byte lane

    // Client byte address and RAM word address
    localparam int addr_w      = 10;
    localparam int word_addr_w = 8;   // 256 words, wraps around at the top

    localparam int client_cnt  = 2;

    // Access sequencer states
    localparam logic [2:0] idle = 3'd0;
    localparam logic [2:0] hi_1 = 3'd1;   // Address cycle of the upper word
    localparam logic [2:0] hi_2 = 3'd2;   // Data cycle of the upper word
    localparam logic [2:0] lo_1 = 3'd3;
    localparam logic [2:0] lo_2 = 3'd4;
    localparam logic [2:0] done = 3'd5;

    // Access size requested by a client, code 2'b11 is never issued
    typedef enum logic [1:0] {
        acc_8  = 2'b00,
        acc_16 = 2'b01,
        acc_32 = 2'b10
    } acc_width_t;

    // One memory word, seen whole for shifting or lane by lane for merging and writes
    typedef union packed {
        logic [data_w-1:0]         word;
        logic [lanes-1:0][7:0]     bytes;
    } mem_word_u;

endpackage

// ==== source/mem_mux.sv ====
module mem_mux (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [mem_pkg::client_cnt-1:0]                      client_requests,
    input  logic [mem_pkg::client_cnt-1:0]                      client_wes,
    input  logic [mem_pkg::client_cnt-1:0][1:0]                 client_widths,
    input  logic [mem_pkg::client_cnt-1:0][mem_pkg::addr_w-1:0] client_addrs,
    input  logic [mem_pkg::client_cnt-1:0][mem_pkg::data_w-1:0] client_wdata,
    input  logic                                                acc_ready,
    input  logic [mem_pkg::data_w-1:0]                          acc_rdata,
    output logic [mem_pkg::client_cnt-1:0]                      client_readies,
    output logic [mem_pkg::client_cnt-1:0][mem_pkg::data_w-1:0] client_rdata,
    output logic                                                acc_request,
    output logic                                                acc_we,
    output mem_pkg::acc_width_t                                 acc_width,
    output logic [mem_pkg::addr_w-1:0]                          acc_addr,
    output logic [mem_pkg::data_w-1:0]                          acc_wdata
);
    import mem_pkg::*;

    logic [$clog2(client_cnt)-1:0] grant_q;
    logic                          grant_valid_q;
    logic [$clog2(client_cnt)-1:0] pick;
    logic [$clog2(client_cnt)-1:0] sel;

    // Lowest numbered requester wins, so scan from the top down
    always_comb begin
        pick = '0;
        for (int i = client_cnt - 1; i >= 0; i--) begin
            if (client_requests[i]) begin
                pick = i[$clog2(client_cnt)-1:0];
            end
        end
    end

    // A fresh grant is visible in the same cycle, before it is latched
    assign sel = grant_valid_q ? grant_q : pick;

    assign acc_request = client_requests[sel];
    assign acc_we      = client_wes[sel];
    assign acc_width   = acc_width_t'(client_widths[sel]);
    assign acc_addr    = client_addrs[sel];
    assign acc_wdata   = client_wdata[sel];

    // Only the granted client sees ready and read data
    always_comb begin
        for (int i = 0; i < client_cnt; i++) begin
            client_readies[i] = acc_ready && (sel == i);
            client_rdata[i]   = (sel == i) ? acc_rdata : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid_q <= 1'b0;
            grant_q       <= '0;
        end else if (!grant_valid_q) begin
            if (|client_requests) begin
                grant_valid_q <= 1'b1;
                grant_q       <= pick;
            end
        end else if (!client_requests[grant_q]) begin
            grant_valid_q <= 1'b0;   // Owner let go, arbitrate again next cycle
        end
    end

endmodule

// ==== source/mem_if.sv ====
module mem_if (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            acc_request,
    input  logic                            acc_we,
    input  mem_pkg::acc_width_t             acc_width,
    input  logic [mem_pkg::addr_w-1:0]      acc_addr,
    input  logic [mem_pkg::data_w-1:0]      acc_wdata,
    input  logic [mem_pkg::data_w-1:0]      ram_rdata,
    output logic                            acc_ready,
    output logic [mem_pkg::data_w-1:0]      acc_rdata,
    output logic [mem_pkg::word_addr_w-1:0] ram_addr,
    output logic [mem_pkg::data_w-1:0]      ram_wdata,
    output logic [mem_pkg::lanes-1:0]       ram_we
);
    import mem_pkg::*;

    logic [2:0]             state_q;
    logic [lane_sel_w-1:0]  lane_off_q;
    logic                   split_q;
    logic                   single_now;
    logic [lane_sel_w-1:0]  hi_shift;
    logic [word_addr_w-1:0] word_addr;
    logic [lanes-1:0]       width_mask;
    logic                   hi_phase;
    mem_word_u              rd_lo;
    mem_word_u              rd_hi;
    mem_word_u              hi_q;
    mem_word_u              merged;

    assign word_addr = acc_addr[addr_w-1:lane_sel_w];
    assign hi_phase  = (state_q == hi_1) || (state_q == hi_2);

    // Bytes of the access that spill into the next word start at this lane distance
    assign hi_shift = ~lane_off_q + 1'b1;

    // The access fits in one word unless it runs past lane 3
    assign single_now = (acc_width == acc_8)
        || (acc_width == acc_16 && acc_addr[lane_sel_w-1:0] != 2'd3)
        || (acc_width == acc_32 && acc_addr[lane_sel_w-1:0] == '0);

    always_comb begin
        case (acc_width)
            acc_8:   width_mask = 4'b0001;
            acc_16:  width_mask = 4'b0011;
            default: width_mask = 4'b1111;
        endcase
    end

    // Upper word goes first on a split access, the index wraps past 255
    assign ram_addr = hi_phase ? word_addr + 1'b1 : word_addr;

    always_comb begin
        ram_we = '0;
        if (hi_phase) begin
            ram_wdata = acc_wdata >> {hi_shift, 3'b000};   // Top client bytes into low lanes
        end else begin
            ram_wdata = acc_wdata << {lane_off_q, 3'b000};
        end
        if (acc_we && state_q == hi_2) begin
            ram_we = width_mask >> hi_shift;
        end
        if (acc_we && state_q == lo_2) begin
            ram_we = width_mask << lane_off_q;
        end
    end

    // Read side, the low word is realigned to byte 0 and the upper bytes come from hi_q
    always_comb begin
        rd_lo.word = ram_rdata >> {lane_off_q, 3'b000};
        rd_hi.word = ram_rdata << {hi_shift, 3'b000};
        for (int i = 0; i < lanes; i++) begin
            if (!width_mask[i]) begin
                merged.bytes[i] = 8'h00;   // Zero-extend short reads
            end else if (split_q && (i + lane_off_q >= lanes)) begin
                merged.bytes[i] = hi_q.bytes[i];
            end else begin
                merged.bytes[i] = rd_lo.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= idle;
            lane_off_q <= '0;
            split_q    <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (acc_request) begin
                        lane_off_q <= acc_addr[lane_sel_w-1:0];
                        split_q    <= !single_now;
                        state_q    <= single_now ? lo_1 : hi_1;
                    end
                end
                hi_1: state_q <= hi_2;
                hi_2: state_q <= lo_1;
                lo_1: state_q <= lo_2;
                lo_2: state_q <= done;
                done: begin
                    if (!acc_request) begin
                        state_q <= idle;   // Client has taken the result
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // RAM data is valid in the second cycle of each word access
    always_ff @(posedge clk) begin
        if (state_q == hi_2) begin
            hi_q <= rd_hi;
        end
        if (state_q == lo_2) begin
            acc_rdata <= merged.word;
        end
    end

    assign acc_ready = (state_q == done) && acc_request;

endmodule

// ==== source/bank_ram.sv ====
module bank_ram (
    input  logic                            clk,
    input  logic [mem_pkg::word_addr_w-1:0] ram_addr,
    input  logic [mem_pkg::data_w-1:0]      ram_wdata,
    input  logic [mem_pkg::lanes-1:0]       ram_we,
    output logic [mem_pkg::data_w-1:0]      ram_rdata
);
    import mem_pkg::*;

    mem_word_u mem [0:(1 << word_addr_w)-1];
    mem_word_u wr_word;

    assign wr_word.word = ram_wdata;

    initial begin
        for (int i = 0; i < (1 << word_addr_w); i++) begin
            mem[i] = '0;
        end
    end

    // Each lane is written on its own, the read returns the old word on a collision
    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes; i++) begin
            if (ram_we[i]) begin
                mem[ram_addr].bytes[i] <= wr_word.bytes[i];
            end
        end
        ram_rdata <= mem[ram_addr].word;
    end

endmodule

// ==== source/mem_subsys.sv ====
module mem_subsys (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [mem_pkg::client_cnt-1:0]                      client_requests,
    input  logic [mem_pkg::client_cnt-1:0]                      client_wes,
    input  logic [mem_pkg::client_cnt-1:0][1:0]                 client_widths,
    input  logic [mem_pkg::client_cnt-1:0][mem_pkg::addr_w-1:0] client_addrs,
    input  logic [mem_pkg::client_cnt-1:0][mem_pkg::data_w-1:0] client_wdata,
    output logic [mem_pkg::client_cnt-1:0][mem_pkg::data_w-1:0] client_rdata,
    output logic [mem_pkg::client_cnt-1:0]                      client_readies
);
    import mem_pkg::*;

    logic                   acc_request;
    logic                   acc_we;
    acc_width_t             acc_width;
    logic [addr_w-1:0]      acc_addr;
    logic [data_w-1:0]      acc_wdata;
    logic                   acc_ready;
    logic [data_w-1:0]      acc_rdata;
    logic [word_addr_w-1:0] ram_addr;
    logic [data_w-1:0]      ram_wdata;
    logic [lanes-1:0]       ram_we;
    logic [data_w-1:0]      ram_rdata;

    mem_mux u_mux (
        .clk             (clk),
        .rst             (rst),
        .client_requests (client_requests),
        .client_wes      (client_wes),
        .client_widths   (client_widths),
        .client_addrs    (client_addrs),
        .client_wdata    (client_wdata),
        .acc_ready       (acc_ready),
        .acc_rdata       (acc_rdata),
        .client_readies  (client_readies),
        .client_rdata    (client_rdata),
        .acc_request     (acc_request),
        .acc_we          (acc_we),
        .acc_width       (acc_width),
        .acc_addr        (acc_addr),
        .acc_wdata       (acc_wdata)
    );

    mem_if u_if (
        .clk         (clk),
        .rst         (rst),
        .acc_request (acc_request),
        .acc_we      (acc_we),
        .acc_width   (acc_width),
        .acc_addr    (acc_addr),
        .acc_wdata   (acc_wdata),
        .ram_rdata   (ram_rdata),
        .acc_ready   (acc_ready),
        .acc_rdata   (acc_rdata),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_we      (ram_we)
    );

    bank_ram u_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata)
    );

endmodule

// ==== tb/mem_subsys_props.sv ====
module mem_subsys_props (
    input logic                           clk,
    input logic                           rst,
    input logic [mem_pkg::client_cnt-1:0] client_readies,
    input logic                           acc_ready,
    input logic [mem_pkg::lanes-1:0]      ram_we,
    input logic [2:0]                     if_state
);
    import mem_pkg::*;

    // The arbiter hands ready to one client at most
    readies_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(client_readies))
        else $error("More than one client ready in the same cycle");

    no_write_in_idle: assert property (@(posedge clk) disable iff (rst)
        (if_state == idle) |-> (ram_we == '0))
        else $error("RAM lane write enable set while the sequencer is idle");

    // Reset parks the sequencer in idle and keeps ready low for the next cycle
    ready_low_after_reset: assert property (@(posedge clk)
        rst |=> (!acc_ready && (if_state == idle)))
        else $error("Sequencer busy or acc_ready high in the cycle after reset");

endmodule

// ==== tb/tb_mem_subsys.sv ====
module tb_mem_subsys;
    import mem_pkg::*;

    logic                              clk;
    logic                              rst;
    logic [client_cnt-1:0]             client_requests;
    logic [client_cnt-1:0]             client_wes;
    logic [client_cnt-1:0][1:0]        client_widths;
    logic [client_cnt-1:0][addr_w-1:0] client_addrs;
    logic [client_cnt-1:0][data_w-1:0] client_wdata;
    logic [client_cnt-1:0][data_w-1:0] client_rdata;
    logic [client_cnt-1:0]             client_readies;

    logic [7:0]        model [0:(1 << addr_w)-1];   // Byte image of the RAM
    int                q_test[$];
    int                q_client[$];
    bit                q_we[$];
    int                q_width[$];
    logic [addr_w-1:0] q_addr[$];
    logic [data_w-1:0] q_data[$];
    int                errors;
    int                checks;
    int                accesses;
    int                test_errors;
    int                test_accesses;
    bit                timed_out;

    mem_subsys DUT (
        .clk             (clk),
        .rst             (rst),
        .client_requests (client_requests),
        .client_wes      (client_wes),
        .client_widths   (client_widths),
        .client_addrs    (client_addrs),
        .client_wdata    (client_wdata),
        .client_rdata    (client_rdata),
        .client_readies  (client_readies)
    );

    bind mem_subsys mem_subsys_props props (
        .clk            (clk),
        .rst            (rst),
        .client_readies (client_readies),
        .acc_ready      (acc_ready),
        .ram_we         (ram_we),
        .if_state       (u_if.state_q)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [1:0] width_code(input int width);
        case (width)
            8:       return acc_8;
            16:      return acc_16;
            default: return acc_32;
        endcase
    endfunction

    // An access needs two words when its last byte lies past lane 3
    function automatic bit crosses_word(input int width, input logic [addr_w-1:0] addr);
        return (width == 16 && addr[1:0] == 2'd3) || (width == 32 && addr[1:0] != 2'd0);
    endfunction

    function automatic logic [data_w-1:0] model_read(input logic [addr_w-1:0] addr,
                                                     input int width);
        logic [data_w-1:0] val;
        val = '0;
        for (int k = 0; k < width / 8; k++) begin
            val[8*k +: 8] = model[(int'(addr) + k) % (1 << addr_w)];   // Wraps at the top
        end
        return val;
    endfunction

    task automatic model_write(input logic [addr_w-1:0] addr, input int width,
                               input logic [data_w-1:0] data);
        for (int k = 0; k < width / 8; k++) begin
            model[(int'(addr) + k) % (1 << addr_w)] = data[8*k +: 8];
        end
    endtask

    task automatic check(input string what, input logic [data_w-1:0] got,
                         input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive(input int i);
        int c;
        c = q_client[i];
        client_wes[c]      = q_we[i];
        client_widths[c]   = width_code(q_width[i]);
        client_addrs[c]    = q_addr[i];
        client_wdata[c]    = q_data[i];
        client_requests[c] = 1'b1;
    endtask

    task automatic wait_ready(input int c, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!client_readies[c] && cycles < 20);
        if (!client_readies[c]) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: client %0d ready did not rise within 20 cycles", $time, c);
        end
    endtask

    task automatic complete(input int i);
        int c;
        c = q_client[i];
        accesses++;
        test_accesses++;
        if (q_we[i]) begin
            model_write(q_addr[i], q_width[i], q_data[i]);
        end else begin
            check($sformatf("client %0d read at %h", c, q_addr[i]), client_rdata[c],
                  model_read(q_addr[i], q_width[i]));
        end
    endtask

    task automatic serve(input int i);
        int c;
        int cycles;
        c = q_client[i];
        drive(i);
        wait_ready(c, cycles);
        if (!timed_out) begin
            check("ready latency", cycles, crosses_word(q_width[i], q_addr[i]) ? 5 : 3);
            complete(i);
            if (q_test[i] == 5) begin
                repeat (2) begin   // Ready and data must hold while the client stalls
                    @(negedge clk);
                    check("ready while held", client_readies[c], 1);
                    if (!q_we[i]) begin
                        check("read data while held", client_rdata[c],
                              model_read(q_addr[i], q_width[i]));
                    end
                end
            end
            client_requests[c] = 1'b0;
        end
    endtask

    // Both clients raise their requests at the same edge and client 0 must win
    task automatic serve_pair(input int i);
        int cycles;
        drive(i);
        drive(i + 1);
        wait_ready(0, cycles);
        if (!timed_out) begin
            check("client 1 ready during client 0 access", client_readies[1], 0);
            check("ready latency", cycles, crosses_word(q_width[i], q_addr[i]) ? 5 : 3);
            complete(i);
            client_requests[0] = 1'b0;
            wait_ready(1, cycles);
        end
        if (!timed_out) begin
            complete(i + 1);
            client_requests[1] = 1'b0;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    t;
        int    c;
        int    w;
        int    wid;
        int    i;
        int    gap;
        int    cur_test;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] d;
        string line;

        rst             = 1'b1;
        client_requests = '0;
        client_wes      = '0;
        client_widths   = '0;
        client_addrs    = '0;
        client_wdata    = '0;
        for (int k = 0; k < (1 << addr_w); k++) begin
            model[k] = 8'h00;
        end
        void'($urandom(32'hb877bcc7));

        fd = $fopen("tb/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("The trace file tb/mem_trace.txt could not be opened");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%d %d %d %d %h %h", t, c, w, wid, a, d);
                if (n == 6) begin
                    q_test.push_back(t);
                    q_client.push_back(c);
                    q_we.push_back(w != 0);
                    q_width.push_back(wid);
                    q_addr.push_back(a);
                    q_data.push_back(d);
                end
            end
            $fclose(fd);
        end

        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        i = 0;
        cur_test = (q_test.size() > 0) ? q_test[0] : 0;
        while (i < q_test.size() && !timed_out) begin
            if (q_test[i] != cur_test) begin
                $display("Test %0d finished: %0d accesses, %0d errors",
                         cur_test, test_accesses, test_errors);
                cur_test      = q_test[i];
                test_accesses = 0;
                test_errors   = 0;
            end
            if (q_test[i] == 4 && q_client[i] == 0 && i + 1 < q_test.size()) begin
                serve_pair(i);
                i += 2;
            end else begin
                serve(i);
                i++;
            end
            gap = int'($urandom % 4);
            repeat (gap + 1) @(negedge clk);   // Request stays low at least one cycle
        end
        $display("Test %0d finished: %0d accesses, %0d errors",
                 cur_test, test_accesses, test_errors);
        $display("Summary: %0d accesses, %0d checks, %0d errors", accesses, checks, errors);
        if (errors == 0 && !timed_out && q_test.size() > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/mem_trace.txt ====
# test client write width(8/16/32) byte_addr(hex) wdata(hex)
# Test 4 lines come in pairs, client 0 then client 1, issued in the same cycle
1 0 1 32 000 11223344
1 1 1 16 004 0000aabb
1 0 1 8  009 0000005c
1 1 0 32 000 00000000
1 0 0 16 004 00000000
1 1 0 8  009 00000000
1 0 0 32 008 00000000
2 0 1 32 011 deadbeef
2 1 0 32 011 00000000
2 1 1 16 017 0000cafe
2 0 0 16 017 00000000
2 0 1 32 3fe 01234567
2 1 0 32 3ff 00000000
2 0 0 32 3fd 00000000
3 0 1 32 020 ffffffff
3 0 1 32 024 ffffffff
3 1 1 8  021 00000000
3 0 1 16 022 00001234
3 1 1 32 023 a5a5a5a5
3 1 1 8  027 00000077
3 0 0 32 020 00000000
3 1 0 32 024 00000000
4 0 1 32 030 13579bdf
4 1 0 32 030 00000000
4 0 0 16 031 00000000
4 1 1 32 033 fedcba98
5 0 0 8  02a 00000000
5 1 0 32 02d 00000000
5 0 0 16 027 00000000

// ==== tb.f ====
source/mem_pkg.sv
source/mem_mux.sv
source/mem_if.sv
source/bank_ram.sv
source/mem_subsys.sv
tb/mem_subsys_props.sv
tb/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_mem_subsys -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
